// ==== logic/spi_pkg.sv ====
`default_nettype none

////////////////////////////////////////
// shared types and register map
////////////////////////////////////////

package spi_pkg;

  // data words
  typedef logic [31:0] spi_word_t;  // command / received word
  typedef logic  [7:0] spi_byte_t;  // one serial byte

  // half period of sclk is div+1 clocks
  typedef logic  [7:0] spi_div_t;

  // byte count minus one, 0 -> 1 byte, 3 -> 4 bytes
  typedef logic  [1:0] spi_cnt_t;

  // register bus address
  typedef logic  [2:0] spi_adr_t;

  ////////////////////////////////////////
  // register addresses
  ////////////////////////////////////////

  localparam spi_adr_t ADR_CFG = 3'd0;  // divider, slave select mask
  localparam spi_adr_t ADR_TXD = 3'd1;  // transmit word
  localparam spi_adr_t ADR_CTL = 3'd2;  // launch, write only
  localparam spi_adr_t ADR_RXD = 3'd3;  // received word, read only
  localparam spi_adr_t ADR_STS = 3'd4;  // busy flag, read only

  // 5..7 unused, access gives an error strobe

endpackage : spi_pkg

`default_nettype wire

// ==== logic/spi_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_reg #(
  parameter int unsigned SSW = 8  // slave select width
)(
  input  logic               clk_i,
  input  logic               rst_n_i,
  // register bus
  input  logic               reg_wen_i,   // write enable
  input  logic               reg_ren_i,   // read enable
  input  spi_pkg::spi_adr_t  reg_adr_i,   // address
  input  spi_pkg::spi_word_t reg_wdt_i,   // write data
  output spi_pkg::spi_word_t reg_rdt_o,   // read data, one cycle later
  output logic               reg_err_o,   // error strobe
  // received word from input repackager
  input  logic               wrd_stb_i,
  input  spi_pkg::spi_word_t wrd_dat_i,
  // command to output repackager
  output logic               cmd_stb_o,
  output spi_pkg::spi_word_t cmd_dat_o,
  output spi_pkg::spi_cnt_t  cmd_cnt_o,
  output logic               cmd_quad_o,
  output logic               cmd_rd_o,
  // configuration
  output spi_pkg::spi_div_t  div_o,
  output logic [SSW-1:0]     ss_msk_o,
  output logic               busy_o
);

  import spi_pkg::*;

  spi_word_t txd;     // transmit word
  spi_word_t rxd;     // last received word
  spi_word_t cfg_rd;  // CFG as seen on readback
  logic      ctl_wr;  // write to CTL
  logic      launch;  // accepted launch
  logic      bad;     // error condition this cycle

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign ctl_wr = reg_wen_i & (reg_adr_i == ADR_CTL);
  assign launch = ctl_wr & ~busy_o;  // rejected while busy

  // unused address or launch on top of a running transfer
  assign bad = ((reg_wen_i | reg_ren_i) & (reg_adr_i > ADR_STS)) | (ctl_wr & busy_o);

  always_comb begin
    cfg_rd           = '0;  // unimplemented bits read zero
    cfg_rd[7:0]      = div_o;
    cfg_rd[8 +: SSW] = ss_msk_o;
  end

  ////////////////////////////////////////
  // configuration and data
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_o    <= '0;
      ss_msk_o <= '0;
    end else if (reg_wen_i && (reg_adr_i == ADR_CFG)) begin
      div_o    <= reg_wdt_i[7:0];
      ss_msk_o <= reg_wdt_i[8 +: SSW];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_wen_i && (reg_adr_i == ADR_TXD)) txd <= reg_wdt_i;
    if (wrd_stb_i) rxd <= wrd_dat_i;  // end of transfer
    if (launch) cmd_dat_o <= txd;     // snapshot, stable till next launch
  end

  // launch and busy flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_stb_o  <= 1'b0;
      cmd_cnt_o  <= '0;
      cmd_quad_o <= 1'b0;
      cmd_rd_o   <= 1'b0;
      busy_o     <= 1'b0;
    end else begin
      cmd_stb_o <= launch;
      if (launch) begin
        cmd_cnt_o  <= reg_wdt_i[1:0];
        cmd_quad_o <= reg_wdt_i[2];
        cmd_rd_o   <= reg_wdt_i[3];  // quad read, ignored in single mode
        busy_o     <= 1'b1;
      end else if (wrd_stb_i) begin
        busy_o <= 1'b0;  // last byte packed
      end
    end
  end

  ////////////////////////////////////////
  // read data and error response
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reg_rdt_o <= '0;
      reg_err_o <= 1'b0;
    end else begin
      reg_err_o <= bad;
      if (reg_ren_i) begin
        case (reg_adr_i)
          ADR_CFG: reg_rdt_o <= cfg_rd;
          ADR_TXD: reg_rdt_o <= txd;
          ADR_RXD: reg_rdt_o <= rxd;
          ADR_STS: reg_rdt_o <= {31'd0, busy_o};
          default: reg_rdt_o <= '0;  // CTL and unused
        endcase
      end
    end
  end

endmodule : spi_reg

`default_nettype wire

// ==== logic/spi_rpo.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_rpo (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // command from register block
  input  logic               cmd_stb_i,
  input  spi_pkg::spi_word_t cmd_dat_i,
  input  spi_pkg::spi_cnt_t  cmd_cnt_i,
  // byte finished in serializer
  input  logic               done_stb_i,
  // byte to serializer
  output logic               byt_stb_o,
  output spi_pkg::spi_byte_t byt_dat_o
);

  import spi_pkg::*;

  spi_word_t sreg;  // bytes not yet issued, next one on top
  spi_cnt_t  left;  // bytes still owed after the one in flight
  logic      nxt;   // issue next byte

  // pace on the serializer, stay quiet after last byte
  assign nxt = done_stb_i & (left != '0);

  ////////////////////////////////////////
  // byte counter and strobe
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      byt_stb_o <= 1'b0;
      left      <= '0;
    end else begin
      byt_stb_o <= 1'b0;  // single cycle
      if (cmd_stb_i) begin
        byt_stb_o <= 1'b1;  // first byte right away
        left      <= cmd_cnt_i;
      end else if (nxt) begin
        byt_stb_o <= 1'b1;
        left      <= left - 2'd1;
      end
    end
  end

  ////////////////////////////////////////
  // shift register, MSB byte first
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_stb_i) begin
      byt_dat_o <= cmd_dat_i[31:24];
      sreg      <= {cmd_dat_i[23:0], 8'h00};
    end else if (nxt) begin
      byt_dat_o <= sreg[31:24];
      sreg      <= {sreg[23:0], 8'h00};
    end
  end

endmodule : spi_rpo

`default_nettype wire

// ==== logic/spi_sclk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_sclk_gen (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              run_i,       // divider enable
  input  spi_pkg::spi_div_t div_i,       // half period minus one
  output logic              sclk_o,      // serial clock, idles low
  output logic              rise_stb_o,  // sclk just went high
  output logic              fall_stb_o   // sclk just went low
);

  import spi_pkg::*;

  spi_div_t cnt;       // clocks in current half period
  logic     half_end;  // last clock of half period

  assign half_end = (cnt == div_i);

  ////////////////////////////////////////
  // divider
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // idle and reset look the same, sclk parked low
    if (!rst_n_i || !run_i) begin
      cnt        <= '0;
      sclk_o     <= 1'b0;
      rise_stb_o <= 1'b0;
      fall_stb_o <= 1'b0;
    end else begin
      rise_stb_o <= 1'b0;
      fall_stb_o <= 1'b0;
      if (half_end) begin
        cnt        <= '0;
        sclk_o     <= ~sclk_o;
        rise_stb_o <= ~sclk_o;  // low -> high
        fall_stb_o <=  sclk_o;  // high -> low
      end else begin
        cnt <= cnt + 8'd1;
      end
    end
  end

endmodule : spi_sclk_gen

`default_nettype wire

// ==== logic/spi_ser.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_ser #(
  parameter int unsigned SSW = 8  // slave select width
)(
  input  logic               clk_i,
  input  logic               rst_n_i,
  // byte from output repackager
  input  logic               byt_stb_i,
  input  spi_pkg::spi_byte_t byt_dat_i,
  // mode and configuration
  input  logic               quad_i,     // four lanes
  input  logic               rd_i,       // quad read
  input  spi_pkg::spi_div_t  div_i,
  input  logic [SSW-1:0]     ss_msk_i,
  input  logic               busy_i,     // transfer in progress
  // finished byte
  output logic               done_stb_o,
  output spi_pkg::spi_byte_t rx_dat_o,
  // SPI pins
  output logic               spi_sclk_o,
  output logic               spi_sclk_e_o,
  input  logic [3:0]         spi_sio_i,
  output logic [3:0]         spi_sio_o,
  output logic [3:0]         spi_sio_e_o,
  output logic [SSW-1:0]     spi_ss_o,   // active high, inverted at pad
  output logic [SSW-1:0]     spi_ss_e_o
);

  import spi_pkg::*;

  spi_byte_t  tx_sr;     // outgoing bits, MSB on the lane
  spi_byte_t  rx_sr;     // incoming bits
  logic [3:0] bit_cnt;   // rising edges in this byte
  logic [3:0] bit_end;   // rising edges per byte
  logic       run;       // byte in progress
  logic       stop;      // closing falling edge
  logic       sclk_run;
  logic       rise_stb;
  logic       fall_stb;

  assign bit_end = quad_i ? 4'd2 : 4'd8;  // nibbles or bits
  assign stop    = fall_stb & (bit_cnt == bit_end);

  // drop run in the stop cycle so no extra edge slips out
  assign sclk_run = run & ~stop;

  spi_sclk_gen sclk_gen_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .run_i      (sclk_run),
    .div_i      (div_i),
    .sclk_o     (spi_sclk_o),
    .rise_stb_o (rise_stb),
    .fall_stb_o (fall_stb)
  );

  ////////////////////////////////////////
  // bit counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run        <= 1'b0;
      bit_cnt    <= '0;
      done_stb_o <= 1'b0;
    end else begin
      done_stb_o <= 1'b0;
      if (byt_stb_i) begin
        run     <= 1'b1;
        bit_cnt <= '0;
      end else if (stop) begin
        run        <= 1'b0;
        done_stb_o <= 1'b1;  // byte complete after last full period
      end else if (rise_stb) begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

  ////////////////////////////////////////
  // shift registers, mode 0
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (byt_stb_i) begin
      tx_sr <= byt_dat_i;  // first bit ahead of first rise
    end else if (fall_stb && !stop) begin
      tx_sr <= quad_i ? {tx_sr[3:0], 4'h0} : {tx_sr[6:0], 1'b0};
    end
    // sample on rise, MISO is sio[1] in single mode
    if (rise_stb) begin
      rx_sr <= quad_i ? {rx_sr[3:0], spi_sio_i} : {rx_sr[6:0], spi_sio_i[1]};
    end
    if (stop) rx_dat_o <= rx_sr;
  end

  assign spi_sio_o = quad_i ? tx_sr[7:4] : {3'b000, tx_sr[7]};  // sio[3] high bit

  ////////////////////////////////////////
  // selects and enables
  ////////////////////////////////////////

  assign spi_sclk_e_o = busy_i;
  assign spi_ss_o     = busy_i ? ss_msk_i : '0;
  assign spi_ss_e_o   = {SSW{busy_i}};

  // single: MOSI only, quad write: all, quad read: none
  assign spi_sio_e_o = !busy_i ? 4'b0000 :
                       !quad_i ? 4'b0001 :
                       rd_i    ? 4'b0000 : 4'b1111;

endmodule : spi_ser

`default_nettype wire

// ==== logic/spi_rpi.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_rpi (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // command start
  input  logic               cmd_stb_i,
  input  spi_pkg::spi_cnt_t  cmd_cnt_i,
  // byte from serializer
  input  logic               done_stb_i,
  input  spi_pkg::spi_byte_t rx_dat_i,
  // packed word to register block
  output logic               wrd_stb_o,
  output spi_pkg::spi_word_t wrd_dat_o
);

  import spi_pkg::*;

  spi_cnt_t left;  // bytes still expected after the next one

  ////////////////////////////////////////
  // byte counter
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wrd_stb_o <= 1'b0;
      left      <= '0;
    end else begin
      wrd_stb_o <= 1'b0;
      if (cmd_stb_i) begin
        left <= cmd_cnt_i;
      end else if (done_stb_i) begin
        if (left == '0) wrd_stb_o <= 1'b1;  // last byte in
        else left <= left - 2'd1;
      end
    end
  end

  ////////////////////////////////////////
  // packing, new bytes enter at the low end
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_stb_i) begin
      wrd_dat_o <= '0;  // missing bytes read zero
    end else if (done_stb_i) begin
      wrd_dat_o <= {wrd_dat_o[23:0], rx_dat_i};
    end
  end

endmodule : spi_rpi

`default_nettype wire

// ==== logic/spi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_master #(
  parameter int unsigned SSW = 8  // slave select width, 1..16
)(
  input  logic               clk_i,
  input  logic               rst_n_i,
  // register bus
  input  logic               reg_wen_i,
  input  logic               reg_ren_i,
  input  spi_pkg::spi_adr_t  reg_adr_i,
  input  spi_pkg::spi_word_t reg_wdt_i,
  output spi_pkg::spi_word_t reg_rdt_o,
  output logic               reg_err_o,
  // SPI pins, tristate pads outside
  output logic               spi_sclk_o,
  output logic               spi_sclk_e_o,
  input  logic [3:0]         spi_sio_i,
  output logic [3:0]         spi_sio_o,
  output logic [3:0]         spi_sio_e_o,
  output logic [SSW-1:0]     spi_ss_o,
  output logic [SSW-1:0]     spi_ss_e_o
);

  import spi_pkg::*;

  // command path
  logic           cmd_stb;
  spi_word_t      cmd_dat;
  spi_cnt_t       cmd_cnt;
  logic           cmd_quad;
  logic           cmd_rd;
  // configuration
  spi_div_t       div;
  logic [SSW-1:0] ss_msk;
  logic           busy;
  // byte path
  logic           byt_stb;
  spi_byte_t      byt_dat;
  logic           done_stb;
  spi_byte_t      rx_dat;
  // word back
  logic           wrd_stb;
  spi_word_t      wrd_dat;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  spi_reg #(
    .SSW (SSW)
  ) reg_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_wen_i  (reg_wen_i),
    .reg_ren_i  (reg_ren_i),
    .reg_adr_i  (reg_adr_i),
    .reg_wdt_i  (reg_wdt_i),
    .reg_rdt_o  (reg_rdt_o),
    .reg_err_o  (reg_err_o),
    .wrd_stb_i  (wrd_stb),
    .wrd_dat_i  (wrd_dat),
    .cmd_stb_o  (cmd_stb),
    .cmd_dat_o  (cmd_dat),
    .cmd_cnt_o  (cmd_cnt),
    .cmd_quad_o (cmd_quad),
    .cmd_rd_o   (cmd_rd),
    .div_o      (div),
    .ss_msk_o   (ss_msk),
    .busy_o     (busy)
  );

  ////////////////////////////////////////
  // repackaging and serializer
  ////////////////////////////////////////

  spi_rpo rpo_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_stb_i  (cmd_stb),
    .cmd_dat_i  (cmd_dat),
    .cmd_cnt_i  (cmd_cnt),
    .done_stb_i (done_stb),  // paces the next byte
    .byt_stb_o  (byt_stb),
    .byt_dat_o  (byt_dat)
  );

  spi_ser #(
    .SSW (SSW)
  ) ser_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .byt_stb_i    (byt_stb),
    .byt_dat_i    (byt_dat),
    .quad_i       (cmd_quad),
    .rd_i         (cmd_rd),
    .div_i        (div),
    .ss_msk_i     (ss_msk),
    .busy_i       (busy),
    .spi_sio_i    (spi_sio_i),
    .done_stb_o   (done_stb),
    .rx_dat_o     (rx_dat),
    .spi_sclk_o   (spi_sclk_o),
    .spi_sclk_e_o (spi_sclk_e_o),
    .spi_sio_o    (spi_sio_o),
    .spi_sio_e_o  (spi_sio_e_o),
    .spi_ss_o     (spi_ss_o),
    .spi_ss_e_o   (spi_ss_e_o)
  );

  spi_rpi rpi_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_stb_i  (cmd_stb),
    .cmd_cnt_i  (cmd_cnt),
    .done_stb_i (done_stb),
    .rx_dat_i   (rx_dat),
    .wrd_stb_o  (wrd_stb),
    .wrd_dat_o  (wrd_dat)
  );

endmodule : spi_master

`default_nettype wire

// ==== verification/spi_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_tb;

  import spi_pkg::*;

  localparam int unsigned SSW        = 8;   // dut default
  localparam int          NUM_SINGLE = 12;
  localparam int          NUM_QUAD   = 6;   // each of quad write and quad read
  localparam int          NUM_XFER   = NUM_SINGLE + 2 * NUM_QUAD + 1;
  // worst case 32 bits at div 255, plus room for register traffic
  localparam int          WDOG_NS    = NUM_XFER * 32 * 2 * 256 * 8 + 200_000;
  localparam spi_word_t   CFG_KEEP   = spi_word_t'((64'd1 << (8 + SSW)) - 64'd1);

  logic           clk = 1'b0;
  logic           rst_n;
  logic           reg_wen;
  logic           reg_ren;
  spi_adr_t       reg_adr;
  spi_word_t      reg_wdt;
  spi_word_t      reg_rdt;
  logic           reg_err;
  logic           sclk;
  logic           sclk_en;
  logic [3:0]     sio_out;
  logic [3:0]     sio_en;
  logic [SSW-1:0] ss;
  logic [SSW-1:0] ss_en;

  integer         seed = 27;
  int             errors = 0;
  int             checks = 0;

  // slave model state
  logic [3:0]     slv_sio = 4'h0;  // lanes driven by the slave
  spi_word_t      slv_reply;       // reply for next transfer, msb first
  spi_word_t      slv_sr;
  spi_word_t      cap;             // bits seen on mosi or quad lanes
  int             rises;
  logic           sclk_q = 1'b0;
  logic           sel_q = 1'b0;
  // pin state expected while a transfer runs
  logic [SSW-1:0] cur_mask;
  logic           cur_quad;
  logic [3:0]     cur_sioe;

  always #4 clk = ~clk;  // 8 ns period

  spi_master dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .reg_wen_i    (reg_wen),
    .reg_ren_i    (reg_ren),
    .reg_adr_i    (reg_adr),
    .reg_wdt_i    (reg_wdt),
    .reg_rdt_o    (reg_rdt),
    .reg_err_o    (reg_err),
    .spi_sclk_o   (sclk),
    .spi_sclk_e_o (sclk_en),
    .spi_sio_i    (slv_sio),
    .spi_sio_o    (sio_out),
    .spi_sio_e_o  (sio_en),
    .spi_ss_o     (ss),
    .spi_ss_e_o   (ss_en)
  );

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  ////////////////////////////////////////
  // register bus access
  ////////////////////////////////////////

  task automatic reg_write(input spi_adr_t adr, input spi_word_t dat, input logic exp_err);
    @(negedge clk);
    reg_wen = 1'b1;
    reg_adr = adr;
    reg_wdt = dat;
    @(negedge clk);
    reg_wen = 1'b0;
    check_flag("reg_err_o", exp_err, reg_err);  // strobe lands the cycle after
  endtask

  task automatic reg_read(input spi_adr_t adr, output spi_word_t dat, input logic exp_err);
    @(negedge clk);
    reg_ren = 1'b1;
    reg_adr = adr;
    @(negedge clk);
    reg_ren = 1'b0;
    dat     = reg_rdt;  // registered read data
    check_flag("reg_err_o", exp_err, reg_err);
  endtask

  // poll STS until busy drops, watchdog covers a stuck flag
  task automatic wait_idle();
    spi_word_t sts;
    sts = 32'd1;
    while (sts[0]) reg_read(ADR_STS, sts, 1'b0);
  endtask

  ////////////////////////////////////////
  // one transfer with random setup
  ////////////////////////////////////////

  task automatic run_transfer(input logic quad, input logic rd, input logic poke);
    spi_word_t      txd;
    spi_word_t      cfg;
    spi_word_t      rdt;
    spi_div_t       div;
    spi_cnt_t       cnt;
    logic [SSW-1:0] mask;
    int             n;
    int             i;
    txd       = $random(seed);
    div       = $random(seed);
    mask      = $random(seed);
    cnt       = $random(seed);
    slv_reply = $random(seed);
    if (mask == '0) mask = 1;  // select at least one slave
    n         = int'(cnt) + 1;
    cur_mask  = mask;
    cur_quad  = quad;
    cur_sioe  = !quad ? 4'b0001 : (rd ? 4'b0000 : 4'b1111);
    cfg           = '0;
    cfg[7:0]      = div;
    cfg[8 +: SSW] = mask;
    reg_write(ADR_CFG, cfg, 1'b0);
    reg_write(ADR_TXD, txd, 1'b0);
    reg_write(ADR_CTL, {28'd0, rd, quad, cnt}, 1'b0);
    if (poke) reg_write(ADR_CTL, $random(seed), 1'b1);  // must be rejected
    wait_idle();
    // 8 bits or 2 nibbles per byte
    check_byte("sclk rises", spi_byte_t'(quad ? 2 * n : 8 * n), spi_byte_t'(rises));
    if (!(quad && rd)) begin
      for (i = 0; i < n; i++) begin
        check_byte("mosi byte", txd[31 - 8 * i -: 8], cap[8 * (n - 1 - i) +: 8]);
      end
    end
    if (!quad || rd) begin
      reg_read(ADR_RXD, rdt, 1'b0);
      check_word("RXD", slv_reply >> (8 * (4 - n)), rdt);  // last byte lowest
    end
    check_flag("spi_sclk_o", 1'b0, sclk);
    check_word("spi_ss_o", '0, spi_word_t'(ss));
  endtask

  ////////////////////////////////////////
  // slave model
  ////////////////////////////////////////

  // top of the reply register onto the lanes
  function automatic logic [3:0] miso_lanes(input spi_word_t sr, input logic quad);
    return quad ? sr[31:28] : {2'b00, sr[31], 1'b0};  // miso on sio[1]
  endfunction

  always @(negedge clk) begin : slave_model
    if (!sel_q && (|ss)) begin
      slv_sr  = slv_reply;  // select asserted
      cap     = '0;
      rises   = 0;
      slv_sio = miso_lanes(slv_sr, cur_quad);
    end else if (sel_q && sclk_q && !sclk) begin
      slv_sr  = cur_quad ? (slv_sr << 4) : (slv_sr << 1);
      slv_sio = miso_lanes(slv_sr, cur_quad);
    end
    if (!sclk_q && sclk) begin
      rises++;
      cap = cur_quad ? {cap[27:0], sio_out} : {cap[30:0], sio_out[0]};
      check_word("spi_ss_o", spi_word_t'(cur_mask), spi_word_t'(ss));
      check_word("spi_ss_e_o", spi_word_t'({SSW{1'b1}}), spi_word_t'(ss_en));
      check_byte("spi_sio_e_o", spi_byte_t'(cur_sioe), spi_byte_t'(sio_en));
      check_flag("spi_sclk_e_o", 1'b1, sclk_en);
    end
    sclk_q = sclk;
    sel_q  = |ss;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    spi_word_t rdt;
    spi_word_t wdt;
    int        a;
    rst_n   = 1'b0;
    reg_wen = 1'b0;
    reg_ren = 1'b0;
    reg_adr = '0;
    reg_wdt = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    // pins idle out of reset
    check_flag("spi_sclk_o", 1'b0, sclk);
    check_flag("spi_sclk_e_o", 1'b0, sclk_en);
    check_word("spi_ss_o", '0, spi_word_t'(ss));
    check_word("spi_ss_e_o", '0, spi_word_t'(ss_en));
    check_byte("spi_sio_e_o", '0, spi_byte_t'(sio_en));
    reg_read(ADR_STS, rdt, 1'b0);
    check_flag("STS busy", 1'b0, rdt[0]);
    repeat (8) begin
      wdt = $random(seed);
      reg_write(ADR_CFG, wdt, 1'b0);
      reg_read(ADR_CFG, rdt, 1'b0);
      check_word("CFG", wdt & CFG_KEEP, rdt);
    end
    repeat (NUM_SINGLE) run_transfer(1'b0, $random(seed), 1'b0);
    repeat (NUM_QUAD) run_transfer(1'b1, 1'b0, 1'b0);  // quad write
    repeat (NUM_QUAD) run_transfer(1'b1, 1'b1, 1'b0);  // quad read
    run_transfer(1'b0, 1'b0, 1'b1);
    // unused addresses
    for (a = 5; a < 8; a++) begin
      reg_write(spi_adr_t'(a), $random(seed), 1'b1);
      reg_read(spi_adr_t'(a), rdt, 1'b1);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WDOG_NS);
    errors++;
    $display("Timeout: the run did not finish within %0d ns", WDOG_NS);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Some tests failed");
    $finish;
  end

endmodule : spi_tb

`default_nettype wire

// ==== vlog.f ====
logic/spi_pkg.sv
logic/spi_reg.sv
logic/spi_rpo.sv
logic/spi_sclk_gen.sv
logic/spi_ser.sv
logic/spi_rpi.sv
logic/spi_master.sv
verification/spi_tb.sv
